// File: run_sim.sh
#!/bin/sh
# build and run the synth testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f synth_top.f \
   --top-module tb_synth_top -o tb_synth_top
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_synth_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$log"; then
   exit 1
fi

exit 0

// File: sim/tb_synth_top.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module tb_synth_top;
   import synth_pkg::*;

   localparam int frame_len      = 256;
   localparam int reset_cycles   = 16;
   localparam int timeout_cycles = 40000;   // 128 frames of tests plus margin

   logic                           clk;
   logic                           rstn;
   logic [`SYNTH_NUM_SWITCHES-1:0] sw;
   logic [`SYNTH_NUM_KEYS-1:0]     note_enn;
   logic                           pwm_out;

   int         cyc = 0;
   int         errors;
   int         checks;
   phase_t     model_acc;
   key_mask_t  held;      // keys the dut sees at the next frame edge
   logic [7:0] sw_held;

   synth_top dut (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .pwm_out  (pwm_out)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      if (rstn)
         cyc <= cyc + 1;
      if (cyc >= timeout_cycles)
      begin
         $display("timeout: run still busy after %0d cycles, errors %0d", cyc, errors);
         $display("Test failed");
         $finish;
      end
   end

   // semitones above C0 per key, key 4 in the top nibble
   function automatic note_code_t scale_note(input logic [3:0] scale, input int key);
      logic [19:0] offsets;
      case (scale)
         4'd0:    offsets = 20'hA7530;
         4'd1:    offsets = 20'hCA730;
         4'd2:    offsets = 20'h87530;
         4'd3:    offsets = 20'h97642;
         4'd4:    offsets = 20'h85320;
         4'd5:    offsets = 20'hA9720;
         4'd6:    offsets = 20'h75320;
         4'd7:    offsets = 20'h76420;
         4'd8:    offsets = 20'h87542;
         4'd9:    offsets = 20'h97530;
         4'd10:   offsets = 20'hC8753;
         4'd11:   offsets = 20'hCB740;
         4'd12:   offsets = 20'h97420;
         4'd13:   offsets = 20'hA8732;
         4'd14:   offsets = 20'hCB975;
         default: offsets = 20'h75420;
      endcase
      return note_code_t'(57 + int'(offsets[4*key +: 4]));
   endfunction

   function automatic int lowest_key(input key_mask_t keys);
      int k;
      k = 0;
      while (k < `SYNTH_NUM_KEYS - 1 && !keys[k])
         k++;
      return k;
   endfunction

   function automatic int wave_sample(input phase_t acc, input key_mask_t keys,
                                      input logic [1:0] wave);
      int p;
      p = int'(acc[7:2]);
      if (keys == '0)
         return 0;   // silent
      case (wave)
         2'd0:    return (p < 32) ? 63 : -64;
         2'd1:    return 2 * p - 64;
         2'd2:    return 63 - 2 * p;
         default: return (p < 16) ? 63 : -64;
      endcase
   endfunction

   function automatic phase_t next_phase(input phase_t acc, input key_mask_t keys,
                                         input logic [7:0] sw_val);
      if (keys == '0)
         return '0;
      return acc + phase_t'(scale_note(sw_val[7:4], lowest_key(keys)));
   endfunction

   task automatic check_duty(input string name, input duty_t got, input duty_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error: %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error: %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   // measure one frame, new inputs go in mid-frame for the next edge
   task automatic play_frame(input key_mask_t keys, input logic [7:0] sw_val);
      duty_t exp;
      int    high_cycles;
      exp = duty_t'(wave_sample(model_acc, held, sw_held[1:0]) + `SYNTH_PWM_OFFSET);
      model_acc = next_phase(model_acc, held, sw_held);
      high_cycles = 0;
      if (cyc % frame_len != 0)
      begin
         errors++;
         $display("frame measurement started off the frame boundary at cycle %0d", cyc);
      end
      for (int i = 0; i < frame_len; i++)
      begin
         @(posedge clk);
         #10;
         if (pwm_out)
            high_cycles++;
         if (i == frame_len / 2)
         begin
            note_enn = ~keys;
            sw       = sw_val;
         end
      end
      held    = keys;
      sw_held = sw_val;
      check_duty("pwm_out high count", duty_t'(high_cycles), exp);
   endtask

   task automatic reset_and_idle();
      for (int i = 0; i < reset_cycles; i++)
      begin
         @(posedge clk);
         #10;
         check_bit("pwm_out", pwm_out, 1'b0);
      end
      rstn = 1'b1;
      for (int i = 0; i < frame_len; i++)   // nothing loaded yet
      begin
         @(posedge clk);
         #10;
         check_bit("pwm_out", pwm_out, 1'b0);
      end
      repeat (3) play_frame('0, 8'h00);
   endtask

   task automatic square_on_key0();
      play_frame(5'b00001, 8'h00);
      repeat (12) play_frame(5'b00001, 8'h00);
   endtask

   task automatic random_key_masks();
      key_mask_t keys;
      play_frame(5'b01010, 8'h01);   // keys 1 and 3, Eb
      for (int i = 0; i < 8; i++)
      begin
         keys = key_mask_t'($urandom_range(31, 1));
         play_frame(keys, 8'h01);
      end
   endtask

   task automatic scale_sweep();
      for (int s = 0; s < 16; s++)
         for (int w = 2; w <= 3; w++)
            repeat (3) play_frame(5'b10000, {4'(s), 2'b00, 2'(w)});
   endtask

   task automatic release_and_repress();
      play_frame('0, 8'h00);
      play_frame('0, 8'h00);
      play_frame(5'b00001, 8'h01);
      repeat (3) play_frame(5'b00001, 8'h01);   // phase restarts at 0
   endtask

   initial
   begin
      clk       = 1'b0;
      rstn      = 1'b0;
      sw        = '0;
      note_enn  = '1;
      errors    = 0;
      checks    = 0;
      model_acc = '0;
      held      = '0;
      sw_held   = '0;
      void'($urandom(32'he5af));
      reset_and_idle();
      square_on_key0();
      random_key_masks();
      scale_sweep();
      release_and_repress();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: src/input_sync.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module input_sync
(
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [`SYNTH_NUM_SWITCHES-1:0] sw,
   input  synth_pkg::key_mask_t           note_enn,
   output synth_pkg::scale_sel_t          scale_sel,
   output synth_pkg::wave_sel_t           wave_sel,
   output synth_pkg::key_mask_t           key_en
);
   import synth_pkg::*;

   localparam int last = `SYNTH_SYNC_STAGES - 1;

   logic [`SYNTH_NUM_SWITCHES-1:0] sw_sync  [`SYNTH_SYNC_STAGES];
   key_mask_t                      key_sync [`SYNTH_SYNC_STAGES];

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < `SYNTH_SYNC_STAGES; i++)
         begin
            sw_sync[i]  <= '0;
            key_sync[i] <= '1;   // all keys released
         end
      end
      else
      begin
         sw_sync[0]  <= sw;
         key_sync[0] <= note_enn;
         for (int i = 1; i < `SYNTH_SYNC_STAGES; i++)
         begin
            sw_sync[i]  <= sw_sync[i-1];
            key_sync[i] <= key_sync[i-1];
         end
      end
   end

   // sw[3:2] spare
   assign scale_sel = scale_sel_t'(sw_sync[last][7:4]);
   assign wave_sel  = wave_sel_t'(sw_sync[last][1:0]);
   assign key_en    = ~key_sync[last];

endmodule

// File: src/note_select.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module note_select
(
   input  synth_pkg::scale_sel_t scale_sel,
   input  synth_pkg::wave_sel_t  wave_sel,
   input  synth_pkg::key_mask_t  key_en,
   synth_bus_if.ctrl             bus
);
   import synth_pkg::*;

   note_code_t scale_notes [`SYNTH_NUM_KEYS];
   logic [2:0] key_idx;

   // five notes per scale, key 0 first
   always_comb
   begin
      case (scale_sel)
         4'd0:
            scale_notes = '{note_c0, note_eb0, note_f0, note_g0, note_bb0};
         4'd1:
            scale_notes = '{note_c0, note_eb0, note_g0, note_bb0, note_c1};
         4'd2:
            scale_notes = '{note_c0, note_eb0, note_f0, note_g0, note_ab0};
         4'd3:
            scale_notes = '{note_d0, note_e0, note_gb0, note_g0, note_a0};
         4'd4:
            scale_notes = '{note_c0, note_d0, note_eb0, note_f0, note_ab0};
         4'd5:
            scale_notes = '{note_c0, note_d0, note_g0, note_a0, note_bb0};
         4'd6:
            scale_notes = '{note_c0, note_d0, note_eb0, note_f0, note_g0};
         4'd7:
            scale_notes = '{note_c0, note_d0, note_e0, note_gb0, note_g0};
         4'd8:
            scale_notes = '{note_d0, note_e0, note_f0, note_g0, note_ab0};
         4'd9:
            scale_notes = '{note_c0, note_eb0, note_f0, note_g0, note_a0};
         4'd10:
            scale_notes = '{note_eb0, note_f0, note_g0, note_ab0, note_c1};
         4'd11:
            scale_notes = '{note_c0, note_e0, note_g0, note_b0, note_c1};
         4'd12:
            scale_notes = '{note_c0, note_d0, note_e0, note_g0, note_a0};
         4'd13:
            scale_notes = '{note_d0, note_eb0, note_g0, note_ab0, note_bb0};
         4'd14:
            scale_notes = '{note_f0, note_g0, note_a0, note_b0, note_c1};
         default:
            scale_notes = '{note_c0, note_d0, note_e0, note_f0, note_g0};
      endcase
   end

   // lowest held key wins
   always_comb
   begin
      key_idx = '0;
      for (int i = `SYNTH_NUM_KEYS - 1; i >= 0; i--)
      begin
         if (key_en[i])
         begin
            key_idx = 3'(i);
         end
      end
   end

   assign bus.note_code  = scale_notes[key_idx];
   assign bus.note_valid = |key_en;
   assign bus.wave_sel   = wave_sel;   // passed on to the shaper

endmodule

// File: src/pwm_modulator.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module pwm_modulator
(
   input  logic    clk,
   input  logic    rstn,
   synth_bus_if.pwm bus,
   output logic    pwm_out
);
   import synth_pkg::*;

   duty_t frame_cnt;
   duty_t high_cnt;
   logic  high_en;

   // free running, wraps every 256 cycles
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         frame_cnt <= '0;
      else
         frame_cnt <= frame_cnt + 1'b1;
   end

   assign bus.frame_end = (frame_cnt == '1);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         high_cnt <= '0;
      else if (bus.frame_end)
         high_cnt <= duty_t'(bus.sample) + duty_t'(`SYNTH_PWM_OFFSET);
      else if (high_en)
         high_cnt <= high_cnt - 1'b1;
   end

   assign high_en = (high_cnt != '0);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         pwm_out <= 1'b0;
      else
         pwm_out <= high_en;   // one flop to the pin
   end

endmodule

// File: src/synth_bus_if.sv
`timescale 1ns/1ps

interface synth_bus_if;
   import synth_pkg::*;

   note_code_t note_code;
   logic       note_valid;
   wave_sel_t  wave_sel;
   sample_t    sample;
   logic       frame_end;   // one cycle per pwm frame

   modport ctrl (output note_code, output note_valid, output wave_sel);

   modport voice (
      input  note_code,
      input  note_valid,
      input  wave_sel,
      input  frame_end,
      output sample
   );

   modport pwm (input sample, output frame_end);

endinterface

// File: src/synth_defines.svh
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

`define SYNTH_NUM_KEYS      5
`define SYNTH_NUM_SWITCHES  8
`define SYNTH_SYNC_STAGES   3

`define SYNTH_NOTE_W        7
`define SYNTH_SAMPLE_W      8
`define SYNTH_PHASE_W       8

`define SYNTH_PWM_OFFSET    127   // mid level of the pwm frame

`endif

// File: src/synth_pkg.sv
package synth_pkg;

`include "synth_defines.svh"

   typedef logic [`SYNTH_NOTE_W-1:0]          note_code_t;
   typedef logic [`SYNTH_NUM_KEYS-1:0]        key_mask_t;
   typedef logic [3:0]                        scale_sel_t;
   typedef logic signed [`SYNTH_SAMPLE_W-1:0] sample_t;
   typedef logic [`SYNTH_SAMPLE_W-1:0]        duty_t;
   typedef logic [`SYNTH_PHASE_W-1:0]         phase_t;

   typedef enum logic [1:0] {
      wave_square   = 2'd0,
      wave_saw_up   = 2'd1,
      wave_saw_down = 2'd2,
      wave_pulse    = 2'd3
   } wave_sel_t;

   // one code per semitone
   localparam note_code_t note_c0  = 7'd57;
   localparam note_code_t note_d0  = 7'd59;
   localparam note_code_t note_eb0 = 7'd60;
   localparam note_code_t note_e0  = 7'd61;
   localparam note_code_t note_f0  = 7'd62;
   localparam note_code_t note_gb0 = 7'd63;
   localparam note_code_t note_g0  = 7'd64;
   localparam note_code_t note_ab0 = 7'd65;
   localparam note_code_t note_a0  = 7'd66;
   localparam note_code_t note_bb0 = 7'd67;
   localparam note_code_t note_b0  = 7'd68;
   localparam note_code_t note_c1  = 7'd69;

endpackage

// File: src/synth_top.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module synth_top
(
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [`SYNTH_NUM_SWITCHES-1:0] sw,
   input  logic [`SYNTH_NUM_KEYS-1:0]     note_enn,
   output logic                           pwm_out
);
   import synth_pkg::*;

   scale_sel_t scale_sel;
   wave_sel_t  wave_sel;
   key_mask_t  key_en;

   synth_bus_if bus ();

   input_sync u_input_sync (
      .clk       (clk),
      .rstn      (rstn),
      .sw        (sw),
      .note_enn  (note_enn),
      .scale_sel (scale_sel),
      .wave_sel  (wave_sel),
      .key_en    (key_en)
   );

   note_select u_note_select (
      .scale_sel (scale_sel),
      .wave_sel  (wave_sel),
      .key_en    (key_en),
      .bus       (bus.ctrl)
   );

   tone_gen u_tone_gen (.clk(clk), .rstn(rstn), .bus(bus.voice));

   pwm_modulator u_pwm_modulator (
      .clk     (clk),
      .rstn    (rstn),
      .bus     (bus.pwm),
      .pwm_out (pwm_out)
   );

endmodule

// File: src/tone_gen.sv
`timescale 1ns/1ps
`include "synth_defines.svh"

module tone_gen
(
   input logic        clk,
   input logic        rstn,
   synth_bus_if.voice bus
);
   import synth_pkg::*;

   localparam sample_t level_hi = 8'sd63;
   localparam sample_t level_lo = -8'sd64;

   phase_t     acc;
   logic [5:0] p;
   sample_t    shaped;

   // advances once per frame, restarts while silent
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         acc <= '0;
      end
      else if (bus.frame_end)
      begin
         if (bus.note_valid)
            acc <= acc + phase_t'(bus.note_code);
         else
            acc <= '0;
      end
   end

   assign p = acc[`SYNTH_PHASE_W-1 -: 6];

   always_comb
   begin
      case (bus.wave_sel)
         wave_square:   shaped = (p < 6'd32) ? level_hi : level_lo;
         wave_saw_up:   shaped = sample_t'({1'b0, p, 1'b0}) + level_lo;
         wave_saw_down: shaped = level_hi - sample_t'({1'b0, p, 1'b0});
         wave_pulse:    shaped = (p < 6'd16) ? level_hi : level_lo;
         default:       shaped = '0;
      endcase
   end

   // silence sits at mid level
   assign bus.sample = bus.note_valid ? shaped : '0;

endmodule

// File: synth_top.f
+incdir+src
src/synth_pkg.sv
src/synth_bus_if.sv
src/input_sync.sv
src/note_select.sv
src/tone_gen.sv
src/pwm_modulator.sv
src/synth_top.sv
sim/tb_synth_top.sv
